//--- cache_pkg.sv
package cache_pkg;

    localparam int NUM_LINES      = 8;
    localparam int WORDS_PER_LINE = 4;

    typedef logic [31:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [WORDS_PER_LINE-1:0] line_t;

    typedef logic [24:0]                         tag_t;
    typedef logic [$clog2(NUM_LINES)-1:0]        index_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]   offset_t;
    typedef logic [27:0]                         line_addr_t;

    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_fields_t;

    typedef struct packed {
        line_addr_t line_addr;
        offset_t    offset;
    } addr_line_t;

    // 30-bit word address seen as cache fields or as a memory line address
    typedef union packed {
        addr_fields_t fields;
        addr_line_t   line_view;
    } proc_addr_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    typedef struct packed {
        index_t     index;
        offset_t    offset;
        tag_t       req_tag;
        logic       hit;
        line_meta_t victim;
        line_addr_t victim_addr;
    } lookup_t;

    typedef struct packed {
        logic  en;
        logic  dirty;
        tag_t  tag;
        line_t line;
    } fill_t;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_REFILL,
        MISS_REFILL_MERGE
    } miss_state_t;

    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_READ,
        BUF_WRITE
    } buf_state_t;

endpackage

//--- cache_addr_decode.sv
`timescale 1ns/1ps

module cache_addr_decode (
    input  cache_pkg::proc_addr_t proc_addr,
    input  cache_pkg::line_meta_t meta,
    output cache_pkg::index_t     index,
    output cache_pkg::lookup_t    lookup
);

    // stored tag and request index packed back into an address
    cache_pkg::proc_addr_t victim_word;

    assign index = proc_addr.fields.index;

    always_comb begin
        victim_word              = '0;
        victim_word.fields.tag   = meta.tag;
        victim_word.fields.index = proc_addr.fields.index;
    end

    always_comb begin
        lookup.index   = proc_addr.fields.index;
        lookup.offset  = proc_addr.line_view.offset;
        lookup.req_tag = proc_addr.fields.tag;
        // only compare against a live line
        lookup.hit     = meta.valid && (meta.tag == proc_addr.fields.tag);
        lookup.victim  = meta;
        // line view drops the offset and leaves {tag, index}
        lookup.victim_addr = victim_word.line_view.line_addr;
    end

endmodule

//--- cache_line_store.sv
`timescale 1ns/1ps

module cache_line_store (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  cache_pkg::index_t     index,
    input  cache_pkg::fill_t      fill,
    input  logic                  wr_hit,
    input  cache_pkg::line_t      wr_line,
    output cache_pkg::line_meta_t meta,
    output cache_pkg::line_t      line
);

    logic [cache_pkg::NUM_LINES-1:0] valid_q;
    logic [cache_pkg::NUM_LINES-1:0] dirty_q;
    cache_pkg::tag_t                 tag_q  [cache_pkg::NUM_LINES];
    cache_pkg::line_t                data_q [cache_pkg::NUM_LINES];

    // state bits per line
    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill.en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= fill.dirty;
        end else if (wr_hit) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill.en) begin
            tag_q[index]  <= fill.tag;
            data_q[index] <= fill.line;
        end else if (wr_hit) begin
            data_q[index] <= wr_line;
        end
    end

    // indexed entry read asynchronously
    always_comb begin
        meta.valid = valid_q[index];
        meta.dirty = dirty_q[index];
        meta.tag   = tag_q[index];
    end

    assign line = data_q[index];

    // a refill never coincides with a write hit
    a_fill_vs_wr_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(fill.en && wr_hit)
    ) else $error("line store: fill and write hit in the same cycle");

endmodule

//--- cache_word_merge.sv
`timescale 1ns/1ps

module cache_word_merge (
    input  cache_pkg::offset_t offset,
    input  logic               use_fill,
    input  cache_pkg::line_t   hit_line,
    input  cache_pkg::line_t   fill_line,
    input  cache_pkg::word_t   wdata,
    output cache_pkg::word_t   rd_word,
    output cache_pkg::line_t   merged_line
);

    cache_pkg::line_t src_line;

    // incoming memory line wins during the refill cycle
    assign src_line = use_fill ? fill_line : hit_line;

    assign rd_word = src_line[offset];

    // drop the write word into its slot
    always_comb begin
        for (int w = 0; w < cache_pkg::WORDS_PER_LINE; w++) begin
            if (offset == cache_pkg::offset_t'(w)) begin
                merged_line[w] = wdata;
            end else begin
                merged_line[w] = src_line[w];
            end
        end
    end

endmodule

//--- cache_miss_ctrl.sv
`timescale 1ns/1ps

module cache_miss_ctrl (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::lookup_t    lookup,
    input  cache_pkg::line_t      victim_line,
    input  logic                  buf_busy,
    input  logic                  buf_rdone,
    input  cache_pkg::line_t      buf_rdata,
    input  cache_pkg::line_t      merged_line,
    output logic                  proc_stall,
    output logic                  wr_hit,
    output cache_pkg::fill_t      fill,
    output logic                  use_fill,
    output logic                  buf_read,
    output logic                  buf_write,
    output cache_pkg::line_addr_t buf_addr,
    output cache_pkg::line_t      buf_wdata
);

    cache_pkg::miss_state_t state_q;
    cache_pkg::miss_state_t state_d;

    // victim waiting for hand-off to the buffer
    logic                  wb_pend_q;
    cache_pkg::line_addr_t wb_addr_q;
    cache_pkg::line_t      wb_line_q;

    logic miss;
    logic victim_dirty;

    assign miss         = (proc_read || proc_write) && !lookup.hit;
    assign victim_dirty = lookup.victim.valid && lookup.victim.dirty;

    // hits only count while no refill is in flight
    assign wr_hit   = (state_q == cache_pkg::MISS_IDLE) && proc_write && lookup.hit;
    assign use_fill = (state_q != cache_pkg::MISS_IDLE) && buf_rdone;

    always_comb begin
        state_d    = state_q;
        proc_stall = 1'b0;
        buf_read   = 1'b0;
        buf_write  = 1'b0;
        fill       = '0;
        fill.tag   = lookup.req_tag;

        case (state_q)
            cache_pkg::MISS_IDLE: begin
                if (miss) begin
                    proc_stall = 1'b1;
                    // wait here while a writeback still owns the memory port
                    if (!buf_busy) begin
                        buf_read = 1'b1;
                        if (proc_write) begin
                            state_d = cache_pkg::MISS_REFILL_MERGE;
                        end else begin
                            state_d = cache_pkg::MISS_REFILL;
                        end
                    end
                end
            end
            cache_pkg::MISS_REFILL,
            cache_pkg::MISS_REFILL_MERGE: begin
                proc_stall = !buf_rdone;
                if (buf_rdone) begin
                    fill.en    = 1'b1;
                    fill.dirty = (state_q == cache_pkg::MISS_REFILL_MERGE);
                    // write miss stores the fetched line with the new word in it
                    if (state_q == cache_pkg::MISS_REFILL_MERGE) begin
                        fill.line = merged_line;
                    end else begin
                        fill.line = buf_rdata;
                    end
                    buf_write = wb_pend_q;
                    state_d   = cache_pkg::MISS_IDLE;
                end
            end
            default: begin
                state_d = cache_pkg::MISS_IDLE;
            end
        endcase
    end

    assign buf_addr  = buf_write ? wb_addr_q :
                       cache_pkg::line_addr_t'({lookup.req_tag, lookup.index});
    assign buf_wdata = wb_line_q;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state_q   <= cache_pkg::MISS_IDLE;
            wb_pend_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (buf_read) begin
                wb_pend_q <= victim_dirty;
            end else if (buf_write) begin
                wb_pend_q <= 1'b0;
            end
        end
    end

    // snapshot of the dirty victim taken before the fill overwrites it
    always_ff @(posedge clk) begin
        if (buf_read && victim_dirty) begin
            wb_addr_q <= lookup.victim_addr;
            wb_line_q <= victim_line;
        end
    end

    a_strobe_exclusive: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(buf_read && buf_write)
    ) else $error("miss ctrl: buf_read and buf_write together");

    // buffer takes a new line op only when it is free
    a_strobe_when_free: assert property (
        @(posedge clk) disable iff (proc_reset)
        (buf_read || buf_write) |-> !buf_busy
    ) else $error("miss ctrl: strobe while buffer busy");

endmodule

//--- mem_write_buffer.sv
`timescale 1ns/1ps

module mem_write_buffer (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  buf_read,
    input  logic                  buf_write,
    input  cache_pkg::line_addr_t buf_addr,
    input  cache_pkg::line_t      buf_wdata,
    input  logic                  mem_ready,
    input  cache_pkg::line_t      mem_rdata,
    output logic                  buf_busy,
    output logic                  buf_rdone,
    output cache_pkg::line_t      buf_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::line_t      mem_wdata
);

    cache_pkg::buf_state_t state_q;
    logic                  rdone_q;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state_q <= cache_pkg::BUF_IDLE;
            rdone_q <= 1'b0;
        end else begin
            rdone_q <= 1'b0;
            case (state_q)
                cache_pkg::BUF_IDLE: begin
                    if (buf_write) begin
                        state_q <= cache_pkg::BUF_WRITE;
                    end else if (buf_read) begin
                        state_q <= cache_pkg::BUF_READ;
                    end
                end
                cache_pkg::BUF_READ: begin
                    if (mem_ready) begin
                        state_q <= cache_pkg::BUF_IDLE;
                        rdone_q <= 1'b1;
                    end
                end
                cache_pkg::BUF_WRITE: begin
                    if (mem_ready) begin
                        state_q <= cache_pkg::BUF_IDLE;
                    end
                end
                default: begin
                    state_q <= cache_pkg::BUF_IDLE;
                end
            endcase
        end
    end

    // line op registered at the strobe and held until mem_ready
    always_ff @(posedge clk) begin
        if (state_q == cache_pkg::BUF_IDLE && (buf_read || buf_write)) begin
            mem_addr <= buf_addr;
        end
        if (state_q == cache_pkg::BUF_IDLE && buf_write) begin
            mem_wdata <= buf_wdata;
        end
        if (state_q == cache_pkg::BUF_READ && mem_ready) begin
            buf_rdata <= mem_rdata;
        end
    end

    assign buf_busy  = (state_q != cache_pkg::BUF_IDLE);
    assign buf_rdone = rdone_q;
    assign mem_read  = (state_q == cache_pkg::BUF_READ);
    assign mem_write = (state_q == cache_pkg::BUF_WRITE);

    a_mem_one_op: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_read && mem_write)
    ) else $error("write buffer: mem_read and mem_write both high");

    // address may not move before the memory answers
    a_mem_addr_hold: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_read || mem_write) && !mem_ready |=> $stable(mem_addr)
    ) else $error("write buffer: mem_addr changed during an operation");

endmodule

//--- cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  proc_read,
    input  logic                  proc_write,
    input  cache_pkg::proc_addr_t proc_addr,
    input  cache_pkg::word_t      proc_wdata,
    output logic                  proc_stall,
    output cache_pkg::word_t      proc_rdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output cache_pkg::line_addr_t mem_addr,
    input  cache_pkg::line_t      mem_rdata,
    output cache_pkg::line_t      mem_wdata,
    input  logic                  mem_ready
);

    cache_pkg::index_t     index;
    cache_pkg::lookup_t    lookup;
    cache_pkg::line_meta_t meta;
    cache_pkg::line_t      line;
    cache_pkg::fill_t      fill;
    cache_pkg::line_t      merged_line;
    logic                  wr_hit;
    logic                  use_fill;

    // control to buffer
    logic                  buf_read;
    logic                  buf_write;
    cache_pkg::line_addr_t buf_addr;
    cache_pkg::line_t      buf_wdata;
    logic                  buf_busy;
    logic                  buf_rdone;
    cache_pkg::line_t      buf_rdata;

    cache_addr_decode i_cache_addr_decode (
        .proc_addr (proc_addr),
        .meta      (meta),
        .index     (index),
        .lookup    (lookup)
    );

    cache_line_store i_cache_line_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .fill       (fill),
        .wr_hit     (wr_hit),
        .wr_line    (merged_line),
        .meta       (meta),
        .line       (line)
    );

    cache_word_merge i_cache_word_merge (
        .offset      (lookup.offset),
        .use_fill    (use_fill),
        .hit_line    (line),
        .fill_line   (buf_rdata),
        .wdata       (proc_wdata),
        .rd_word     (proc_rdata),
        .merged_line (merged_line)
    );

    cache_miss_ctrl i_cache_miss_ctrl (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_read   (proc_read),
        .proc_write  (proc_write),
        .lookup      (lookup),
        .victim_line (line),
        .buf_busy    (buf_busy),
        .buf_rdone   (buf_rdone),
        .buf_rdata   (buf_rdata),
        .merged_line (merged_line),
        .proc_stall  (proc_stall),
        .wr_hit      (wr_hit),
        .fill        (fill),
        .use_fill    (use_fill),
        .buf_read    (buf_read),
        .buf_write   (buf_write),
        .buf_addr    (buf_addr),
        .buf_wdata   (buf_wdata)
    );

    mem_write_buffer i_mem_write_buffer (
        .clk        (clk),
        .proc_reset (proc_reset),
        .buf_read   (buf_read),
        .buf_write  (buf_write),
        .buf_addr   (buf_addr),
        .buf_wdata  (buf_wdata),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .buf_busy   (buf_busy),
        .buf_rdone  (buf_rdone),
        .buf_rdata  (buf_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

//--- tb_cache_top.sv
`timescale 1ns/1ps

module tb_cache_top;

    localparam int NUM_REQ      = 600;
    localparam int MAX_DELAY    = 4;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_LINES    = 64;
    localparam int CYCLE_LIMIT  = NUM_REQ * (MAX_DELAY * 2 + 4) + RESET_CYCLES;

    logic                  clk;
    logic                  proc_reset;
    logic                  proc_read;
    logic                  proc_write;
    cache_pkg::proc_addr_t proc_addr;
    cache_pkg::word_t      proc_wdata;
    logic                  proc_stall;
    cache_pkg::word_t      proc_rdata;
    logic                  mem_read;
    logic                  mem_write;
    cache_pkg::line_addr_t mem_addr;
    cache_pkg::line_t      mem_rdata;
    cache_pkg::line_t      mem_wdata;
    logic                  mem_ready;

    int seed;
    int cycle_count = 0;

    // memory model
    cache_pkg::line_t mem_lines [MEM_LINES];
    bit               mem_pending;
    int               mem_wait;

    // reference model with flat words and shadow tags
    cache_pkg::word_t ref_words [MEM_LINES * 4];
    bit               sh_valid  [8];
    bit               sh_dirty  [8];
    int               sh_tag    [8];

    // expected memory traffic
    bit                    read_expected;
    cache_pkg::line_addr_t exp_read_addr;
    cache_pkg::line_addr_t wb_exp_addr [$];
    cache_pkg::line_t      wb_exp_line [$];

    cache_top i_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_run();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cache_pkg::word_t expected,
                              input cache_pkg::word_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_line(input string name, input cache_pkg::line_t expected,
                              input cache_pkg::line_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input cache_pkg::line_addr_t expected,
                              input cache_pkg::line_addr_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_run();
        end
    endtask

    function automatic cache_pkg::line_t ref_line(input int line_no);
        cache_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w] = ref_words[line_no * 4 + w];
        end
        return l;
    endfunction

    // one memory model step per falling edge
    task automatic serve_memory();
        if (mem_ready) begin
            mem_ready   = 1'b0;
            mem_pending = 1'b0;
        end else if (mem_read || mem_write) begin
            if (!mem_pending) begin
                mem_pending = 1'b1;
                mem_wait    = 1 + $unsigned($random(seed)) % MAX_DELAY;
                if (mem_read) begin
                    if (!read_expected) begin
                        $display("memory read started at %0t with no predicted miss", $time);
                        stop_run();
                    end
                    check_addr("mem_addr", exp_read_addr, mem_addr);
                    read_expected = 1'b0;
                end else begin
                    if (wb_exp_addr.size() == 0) begin
                        $display("memory write started at %0t with no dirty eviction", $time);
                        stop_run();
                    end
                    check_addr("mem_addr", wb_exp_addr.pop_front(), mem_addr);
                    check_line("mem_wdata", wb_exp_line.pop_front(), mem_wdata);
                end
            end
            mem_wait--;
            if (mem_wait == 0) begin
                mem_ready = 1'b1;
                if (mem_read) begin
                    mem_rdata = mem_lines[mem_addr[5:0]];
                end else begin
                    mem_lines[mem_addr[5:0]] = mem_wdata;
                end
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        serve_memory();
    endtask

    task automatic run_request(input bit is_write, input int tag, input int idx, input int off,
                               input cache_pkg::word_t wdata, output bit hit);
        cache_pkg::proc_addr_t addr;
        int line_no;
        int word_no;
        int victim_no;
        line_no = tag * 8 + idx;
        word_no = line_no * 4 + off;
        hit     = sh_valid[idx] && (sh_tag[idx] == tag);
        addr                  = '0;
        addr.fields.tag       = cache_pkg::tag_t'(tag);
        addr.fields.index     = cache_pkg::index_t'(idx);
        addr.fields.offset    = cache_pkg::offset_t'(off);
        if (!hit) begin
            read_expected = 1'b1;
            exp_read_addr = cache_pkg::line_addr_t'(line_no);
            if (sh_valid[idx] && sh_dirty[idx]) begin
                victim_no = sh_tag[idx] * 8 + idx;
                wb_exp_addr.push_back(cache_pkg::line_addr_t'(victim_no));
                wb_exp_line.push_back(ref_line(victim_no));
            end
        end
        proc_read  = !is_write;
        proc_write = is_write;
        proc_addr  = addr;
        proc_wdata = wdata;
        #5;
        if (hit) begin
            check_flag("proc_stall", 1'b0, proc_stall);
        end
        while (proc_stall) begin
            next_cycle();
            #5;
        end
        if (!hit && read_expected) begin
            $display("miss at %0t finished without a memory read", $time);
            stop_run();
        end
        if (!is_write) begin
            check_word("proc_rdata", ref_words[word_no], proc_rdata);
        end
        next_cycle();
        // request committed at the last rising edge
        if (is_write) begin
            ref_words[word_no] = wdata;
        end
        if (!hit) begin
            sh_valid[idx] = 1'b1;
            sh_tag[idx]   = tag;
            sh_dirty[idx] = is_write;
        end else if (is_write) begin
            sh_dirty[idx] = 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_run();
        end
    end

    initial begin
        int  tag;
        int  idx;
        int  off;
        int  wr_off;
        int  follow_up;
        bit  is_write;
        bit  hit;
        cache_pkg::word_t wdata;

        seed       = 92;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        mem_pending   = 1'b0;
        mem_wait      = 0;
        read_expected = 1'b0;
        exp_read_addr = '0;
        follow_up     = 0;
        wr_off        = 0;
        tag = 0;
        idx = 0;
        off = 0;

        for (int i = 0; i < MEM_LINES; i++) begin
            for (int w = 0; w < 4; w++) begin
                mem_lines[i][w]      = $random(seed);
                ref_words[i * 4 + w] = mem_lines[i][w];
            end
        end
        for (int i = 0; i < 8; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
            sh_tag[i]   = 0;
        end

        repeat (RESET_CYCLES) next_cycle();
        proc_reset = 1'b0;
        #5;
        check_flag("proc_stall", 1'b0, proc_stall);
        check_flag("mem_read", 1'b0, mem_read);
        check_flag("mem_write", 1'b0, mem_write);
        next_cycle();

        for (int n = 0; n < NUM_REQ; n++) begin
            if (follow_up == 2) begin
                // read a neighbour word of the line just write-missed
                is_write  = 1'b0;
                off       = (wr_off + 1) % 4;
                follow_up = 1;
            end else if (follow_up == 1) begin
                // then the written word itself
                is_write  = 1'b0;
                off       = wr_off;
                follow_up = 0;
            end else begin
                is_write = ($unsigned($random(seed)) % 5) < 2;
                tag      = $unsigned($random(seed)) % 8;
                idx      = $unsigned($random(seed)) % 8;
                off      = $unsigned($random(seed)) % 4;
            end
            wdata = $random(seed);
            run_request(is_write, tag, idx, off, wdata, hit);
            if (is_write && !hit) begin
                follow_up = 2;
                wr_off    = off;
            end
        end

        // let the last posted writeback drain
        proc_read  = 1'b0;
        proc_write = 1'b0;
        while (wb_exp_addr.size() != 0 || mem_read || mem_write || mem_ready) begin
            next_cycle();
        end
        repeat (3) next_cycle();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- flist.f
cache_pkg.sv
cache_addr_decode.sv
cache_line_store.sv
cache_word_merge.sv
cache_miss_ctrl.sv
mem_write_buffer.sv
cache_top.sv
tb_cache_top.sv
